//--- Makefile
# Verilator build and run for the interrupt section testbench

VERILATOR ?= verilator
TOP       ?= tb_reflet_periph
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Test completed successfully

SRCS := $(wildcard source/*.sv tests/*.sv include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+include
source/reflet_pkg.sv
source/reflet_rw_register.sv
source/reflet_rwe_register.sv
source/reflet_timer.sv
source/reflet_exti.sv
source/reflet_periph_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_reflet_periph.sv

//--- include/reflet_consts.svh
// Shared constants for the peripheral bus: widths, base addresses and register map
`ifndef REFLET_CONSTS_SVH
`define REFLET_CONSTS_SVH

// bus widths
`define REFLET_WORDSIZE 16
`define REFLET_ADDRSIZE 16

// every peripheral decodes a window of three consecutive addresses
`define REFLET_WINDOW_SIZE 3

// interrupt controller window
`define REFLET_EXTI_BASE 16'hFF0C
`define REFLET_EXTI_ENABLE 0
`define REFLET_EXTI_LEVEL 1
`define REFLET_EXTI_STATUS 2

// timer window
`define REFLET_TIMER_BASE 16'hFF10
`define REFLET_TIMER_RELOAD 0
`define REFLET_TIMER_CONTROL 1
`define REFLET_TIMER_COUNT 2
// run flag position inside the control register
`define REFLET_TIMER_RUN_BIT 0

// interrupt sources are gpio, uart and timer (status bits 0, 1, 2)
`define REFLET_INT_SOURCES 3
// number of CPU interrupt lines
`define REFLET_INT_LINES 4

`endif

//--- source/reflet_exti.sv
// External interrupt controller mapping peripheral sources onto the CPU interrupt lines
`include "reflet_consts.svh"

module reflet_exti (
    input  logic                 clk,
    input  logic                 rst_n,
    // bus cycle valid
    input  logic                 enable,
    input  reflet_pkg::addr_t    addr,
    input  logic                 write_en,
    input  reflet_pkg::word_t    data_in,
    output reflet_pkg::word_t    data_out,
    // lines toward the CPU
    output reflet_pkg::cpu_int_t cpu_int,
    // one-cycle request pulses from the peripherals
    input  logic                 gpio_int,
    input  logic                 uart_int,
    input  logic                 timer_int
);
    import reflet_pkg::*;

    localparam int sources = `REFLET_INT_SOURCES;

    // only the bits of real sources may be pending
    localparam reg8_t source_mask = reg8_t'((1 << sources) - 1);

    logic    in_window;
    addr_t   rel_addr;
    offset_t offset;

    // window decode
    assign in_window = enable
                    && (addr >= addr_t'(`REFLET_EXTI_BASE))
                    && (addr < addr_t'(`REFLET_EXTI_BASE + `REFLET_WINDOW_SIZE));
    assign rel_addr  = addr - addr_t'(`REFLET_EXTI_BASE);
    assign offset    = rel_addr[1:0];

    reg8_t enable_reg;
    reg8_t level_reg;
    reg8_t status_reg;
    reg8_t enable_dout;
    reg8_t level_dout;
    reg8_t status_dout;
    reg8_t pulses;
    reg8_t status_wdata;

    // incoming requests in status bit order
    assign pulses = {5'b0, timer_int, uart_int, gpio_int};

    // software writes cannot set bits without a source
    assign status_wdata = data_in[7:0] & source_mask;

    // bit i enables source i
    reflet_rw_register #(.width(8), .reg_addr(`REFLET_EXTI_ENABLE), .default_value(8'h00))
    u_enable_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (in_window),
        .addr     (offset),
        .write_en (write_en),
        .data_in  (data_in[7:0]),
        .data_out (enable_dout),
        .data     (enable_reg)
    );

    // bits 2i+1:2i give the line of source i
    reflet_rw_register #(.width(8), .reg_addr(`REFLET_EXTI_LEVEL), .default_value(8'h00))
    u_level_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (in_window),
        .addr     (offset),
        .write_en (write_en),
        .data_in  (data_in[7:0]),
        .data_out (level_dout),
        .data     (level_reg)
    );

    // pending flags, set by pulses and cleared by writing zeros
    // a pulse in the same cycle as a write keeps old status OR pulse
    reflet_rwe_register #(.width(8), .reg_addr(`REFLET_EXTI_STATUS), .default_value(8'h00))
    u_status_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (in_window),
        .addr          (offset),
        .write_en      (write_en),
        .data_in       (status_wdata),
        .data_out      (status_dout),
        .data          (status_reg),
        .data_override (status_reg | pulses),
        .override      (|pulses)
    );

    // per-source line selection, one-hot on the level field
    cpu_int_t src_line [sources];

    for (genvar i = 0; i < sources; i++) begin : g_src
        int_level_t src_level;
        assign src_level = level_reg[2*i +: 2];
        // only an enabled and pending source drives its line
        assign src_line[i] = (enable_reg[i] && status_reg[i])
                           ? (cpu_int_t'(1) << src_level) : '0;
    end

    // several sources may share one line
    always_comb begin
        cpu_int = '0;
        for (int i = 0; i < sources; i++) begin
            cpu_int = cpu_int | src_line[i];
        end
    end

    // at most one register is selected, the others read zero
    assign data_out = word_t'(enable_dout | level_dout | status_dout);

endmodule

//--- source/reflet_periph_top.sv
// Interrupt section top joining the timer and the interrupt controller on one bus
module reflet_periph_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // shared bus from the CPU
    input  logic                 enable,
    input  reflet_pkg::addr_t    addr,
    input  logic                 write_en,
    input  reflet_pkg::word_t    data_in,
    output reflet_pkg::word_t    data_out,
    // CPU interrupt lines
    output reflet_pkg::cpu_int_t cpu_int,
    // external request pulses
    input  logic                 gpio_int,
    input  logic                 uart_int
);
    import reflet_pkg::*;

    word_t timer_dout;
    word_t exti_dout;
    logic  timer_int;

    // timer, its wrap pulse goes straight to the controller
    reflet_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .addr      (addr),
        .write_en  (write_en),
        .data_in   (data_in),
        .data_out  (timer_dout),
        .timer_int (timer_int)
    );

    // interrupt controller
    reflet_exti u_exti (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .addr      (addr),
        .write_en  (write_en),
        .data_in   (data_in),
        .data_out  (exti_dout),
        .cpu_int   (cpu_int),
        .gpio_int  (gpio_int),
        .uart_int  (uart_int),
        .timer_int (timer_int)
    );

    // windows do not overlap, unaddressed peripherals return zero
    assign data_out = timer_dout | exti_dout;

endmodule

//--- source/reflet_pkg.sv
// Common vector types for the peripheral bus and the interrupt section
`include "reflet_consts.svh"

package reflet_pkg;

    // one data word on the system bus
    typedef logic [`REFLET_WORDSIZE-1:0] word_t;

    // full bus address
    typedef logic [`REFLET_ADDRSIZE-1:0] addr_t;

    // register index inside a peripheral window
    // two bits cover the three registers of a window
    typedef logic [1:0] offset_t;

    // byte-wide control or status register
    typedef logic [7:0] reg8_t;

    // selects one of the CPU interrupt lines
    typedef logic [$clog2(`REFLET_INT_LINES)-1:0] int_level_t;

    // the set of CPU interrupt lines, one bit per line
    typedef logic [`REFLET_INT_LINES-1:0] cpu_int_t;

endpackage

//--- source/reflet_rw_register.sv
// Addressable read/write register with reset value and gated read-back
module reflet_rw_register #(
    parameter int width = 8,
    parameter int reg_addr = 0,
    parameter logic [width-1:0] default_value = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // high while the owning peripheral's window is addressed
    input  logic                 enable,
    input  reflet_pkg::offset_t  addr,
    input  logic                 write_en,
    input  logic [width-1:0]     data_in,
    // bus read-back, zero unless this register is selected
    output logic [width-1:0]     data_out,
    // stored value for the owning peripheral
    output logic [width-1:0]     data
);
    import reflet_pkg::*;

    // position of this register inside the window
    localparam offset_t reg_offset = offset_t'(reg_addr);

    logic selected;

    // window active and offset matching
    assign selected = enable && (addr == reg_offset);

    // load on a selected bus write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data <= default_value;
        end else if (selected && write_en) begin
            data <= data_in;
        end
    end

    // drive zero when not selected so several registers can be ORed
    assign data_out = selected ? data : '0;

endmodule

//--- source/reflet_rwe_register.sv
// Read/write register whose contents the hardware can override over the bus
module reflet_rwe_register #(
    parameter int width = 8,
    parameter int reg_addr = 0,
    parameter logic [width-1:0] default_value = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // high while the owning peripheral's window is addressed
    input  logic                 enable,
    input  reflet_pkg::offset_t  addr,
    input  logic                 write_en,
    input  logic [width-1:0]     data_in,
    // bus read-back, zero unless selected
    output logic [width-1:0]     data_out,
    // stored value for the owning peripheral
    output logic [width-1:0]     data,
    // value loaded by the hardware side
    input  logic [width-1:0]     data_override,
    // hardware load request, wins over a bus write
    input  logic                 override
);
    import reflet_pkg::*;

    localparam offset_t reg_offset = offset_t'(reg_addr);

    logic selected;
    logic bus_write;

    assign selected  = enable && (addr == reg_offset);
    assign bus_write = selected && write_en;

    // hardware update first, bus write only when the hardware is idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data <= default_value;
        end else if (override) begin
            data <= data_override;
        end else if (bus_write) begin
            data <= data_in;
        end
    end

    // read-back shows the stored value, not the pending override
    assign data_out = selected ? data : '0;

endmodule

//--- source/reflet_timer.sv
// Down-counting timer on the peripheral bus that pulses an interrupt on each wrap
`include "reflet_consts.svh"

module reflet_timer (
    input  logic              clk,
    input  logic              rst_n,
    // bus cycle valid
    input  logic              enable,
    input  reflet_pkg::addr_t addr,
    input  logic              write_en,
    input  reflet_pkg::word_t data_in,
    output reflet_pkg::word_t data_out,
    // one-cycle pulse after every wrap
    output logic              timer_int
);
    import reflet_pkg::*;

    localparam offset_t count_offset = offset_t'(`REFLET_TIMER_COUNT);

    logic    in_window;
    addr_t   rel_addr;
    offset_t offset;

    // window decode
    assign in_window = enable
                    && (addr >= addr_t'(`REFLET_TIMER_BASE))
                    && (addr < addr_t'(`REFLET_TIMER_BASE + `REFLET_WINDOW_SIZE));
    assign rel_addr  = addr - addr_t'(`REFLET_TIMER_BASE);
    assign offset    = rel_addr[1:0];

    word_t reload;
    word_t reload_dout;
    reg8_t control;
    reg8_t control_dout;
    word_t count;
    word_t count_dout;
    logic  run;

    // reload value, full word
    reflet_rw_register #(.width(16), .reg_addr(`REFLET_TIMER_RELOAD), .default_value(16'h0000))
    u_reload_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (in_window),
        .addr     (offset),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (reload_dout),
        .data     (reload)
    );

    // control byte, only the run flag has a meaning
    reflet_rw_register #(.width(8), .reg_addr(`REFLET_TIMER_CONTROL), .default_value(8'h00))
    u_control_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (in_window),
        .addr     (offset),
        .write_en (write_en),
        .data_in  (data_in[7:0]),
        .data_out (control_dout),
        .data     (control)
    );

    assign run = control[`REFLET_TIMER_RUN_BIT];

    // counter steps down while running
    // at zero it reloads and flags the wrap for one cycle
    // stopping holds the count, restarting resumes from it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count     <= '0;
            timer_int <= 1'b0;
        end else begin
            timer_int <= 1'b0;
            if (run) begin
                if (count == '0) begin
                    count     <= reload;
                    timer_int <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    // current count is read-only, writes to its offset are dropped
    assign count_dout = (in_window && offset == count_offset) ? count : '0;

    assign data_out = reload_dout | word_t'(control_dout) | count_dout;

endmodule

//--- tests/tb_checker.sv
// Testbench checker that models the exti and timer registers and compares the DUT outputs
`include "reflet_consts.svh"

module tb_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,
    input  reflet_pkg::addr_t    addr,
    input  logic                 write_en,
    input  reflet_pkg::word_t    data_in,
    input  reflet_pkg::word_t    data_out,
    input  reflet_pkg::cpu_int_t cpu_int,
    input  logic                 gpio_int,
    input  logic                 uart_int,
    // last cycle of a table step and the comparisons it asks for
    input  logic                 step_done,
    input  logic                 check_data,
    input  logic                 check_int,
    input  reflet_pkg::word_t    exp_value,
    input  logic [159:0]         test_name,
    output int                   pass_count,
    output int                   fail_count
);
    import reflet_pkg::*;

    localparam addr_t a_en = `REFLET_EXTI_BASE + `REFLET_EXTI_ENABLE;
    localparam addr_t a_lv = `REFLET_EXTI_BASE + `REFLET_EXTI_LEVEL;
    localparam addr_t a_st = `REFLET_EXTI_BASE + `REFLET_EXTI_STATUS;
    localparam addr_t a_rl = `REFLET_TIMER_BASE + `REFLET_TIMER_RELOAD;
    localparam addr_t a_ct = `REFLET_TIMER_BASE + `REFLET_TIMER_CONTROL;
    localparam addr_t a_cn = `REFLET_TIMER_BASE + `REFLET_TIMER_COUNT;
    // pending bits that a real source can hold
    localparam reg8_t src_mask = reg8_t'((1 << `REFLET_INT_SOURCES) - 1);

    // register model, as it stands after the last rising edge
    reg8_t m_enable;
    reg8_t m_level;
    reg8_t m_status;
    word_t m_reload;
    reg8_t m_control;
    word_t m_count;
    logic  m_tpulse;
    logic  model_valid;
    logic  test_err;

    // each enabled and pending source drives the line named by its level field
    function automatic cpu_int_t lines_for(input reg8_t en, input reg8_t lv, input reg8_t st);
        cpu_int_t lines;
        lines = '0;
        for (int i = 0; i < `REFLET_INT_SOURCES; i++) begin
            if (en[i] && st[i]) begin
                lines[lv[2*i +: 2]] = 1'b1;
            end
        end
        return lines;
    endfunction

    // unmapped addresses read zero
    function automatic word_t read_value(input addr_t a);
        case (a)
            a_en:    return word_t'(m_enable);
            a_lv:    return word_t'(m_level);
            a_st:    return word_t'(m_status);
            a_rl:    return m_reload;
            a_ct:    return word_t'(m_control);
            a_cn:    return m_count;
            default: return '0;
        endcase
    endfunction

    task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
        $display("Mismatch in %0s: %0s expected 0x%h actual 0x%h",
                 test_name, what, expected, actual);
        test_err = 1'b1;
    endtask

    initial begin
        pass_count  = 0;
        fail_count  = 0;
        model_valid = 1'b0;
        test_err    = 1'b0;
    end

    // mid-cycle sampling, inputs are driven just after the rising edge
    always @(negedge clk) begin : watch
        reg8_t    pulses;
        logic     bus_wr;
        cpu_int_t exp_lines;
        if (model_valid) begin
            exp_lines = lines_for(m_enable, m_level, m_status);
            if (cpu_int !== exp_lines) begin
                report_mismatch("cpu_int", word_t'(exp_lines), word_t'(cpu_int));
            end
            if (enable && !write_en && data_out !== read_value(addr)) begin
                report_mismatch("read data", read_value(addr), data_out);
            end
            // values written in the stimulus table
            if (check_data && data_out !== exp_value) begin
                report_mismatch("table read data", exp_value, data_out);
            end
            if (check_int && word_t'(cpu_int) !== exp_value) begin
                report_mismatch("table cpu_int", exp_value, word_t'(cpu_int));
            end
            if (step_done) begin
                if (test_err) begin
                    fail_count++;
                    $display("FAIL %0s", test_name);
                end else begin
                    pass_count++;
                    $display("PASS %0s", test_name);
                end
                test_err = 1'b0;
            end
        end
        if (!rst_n) begin
            m_enable    = '0;
            m_level     = '0;
            m_status    = '0;
            m_reload    = '0;
            m_control   = '0;
            m_count     = '0;
            m_tpulse    = 1'b0;
            model_valid = 1'b1;
        end else begin
            bus_wr = enable && write_en;
            // timer pulse of this cycle is a source too
            pulses = {5'b0, m_tpulse, uart_int, gpio_int};
            // counter uses the run flag and reload from before this edge
            if (m_control[0] && m_count == '0) begin
                m_count  = m_reload;
                m_tpulse = 1'b1;
            end else begin
                if (m_control[0]) begin
                    m_count = m_count - 16'd1;
                end
                m_tpulse = 1'b0;
            end
            // a pulse beats a status write in the same cycle
            if (pulses != '0) begin
                m_status = m_status | pulses;
            end else if (bus_wr && addr == a_st) begin
                m_status = data_in[7:0] & src_mask;
            end
            if (bus_wr) begin
                case (addr)
                    a_en:    m_enable = data_in[7:0];
                    a_lv:    m_level = data_in[7:0];
                    a_rl:    m_reload = data_in;
                    a_ct:    m_control = data_in[7:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- tests/tb_clock.sv
// Testbench clock source, free running with a fixed period
module tb_clock #(
    parameter int period = 4
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    // half a period low, half high
    always begin
        #(period / 2);
        clk = ~clk;
    end

endmodule

//--- tests/tb_reflet_periph.sv
// Testbench top for the interrupt section that applies a stimulus table over the bus and pulse inputs
`include "reflet_consts.svh"

module tb_reflet_periph;
    import reflet_pkg::*;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_PULSE, OP_WAIT} op_t;

    typedef struct packed {
        op_t          op;
        addr_t        addr;
        // write data or the length of a wait in cycles
        word_t        data;
        // {uart, gpio}
        logic [1:0]   mask;
        // mask comes from the LCG and only the register model checks it
        logic         rnd;
        // read data for reads and cpu_int for everything else
        word_t        expected;
        logic [159:0] name;
    } step_t;

    localparam addr_t a_en = `REFLET_EXTI_BASE + `REFLET_EXTI_ENABLE;
    localparam addr_t a_lv = `REFLET_EXTI_BASE + `REFLET_EXTI_LEVEL;
    localparam addr_t a_st = `REFLET_EXTI_BASE + `REFLET_EXTI_STATUS;
    localparam addr_t a_rl = `REFLET_TIMER_BASE + `REFLET_TIMER_RELOAD;
    localparam addr_t a_ct = `REFLET_TIMER_BASE + `REFLET_TIMER_CONTROL;
    localparam addr_t a_cn = `REFLET_TIMER_BASE + `REFLET_TIMER_COUNT;
    localparam int clk_period    = 4;
    localparam int reset_cycles  = 10;
    localparam int margin_cycles = 50;

    logic         clk;
    logic         rst_n;
    logic         enable;
    logic         write_en;
    addr_t        addr;
    word_t        data_in;
    word_t        data_out;
    cpu_int_t     cpu_int;
    logic         gpio_int;
    logic         uart_int;
    logic         step_done;
    logic         check_data;
    logic         check_int;
    word_t        exp_value;
    logic [159:0] test_name;
    int           pass_count;
    int           fail_count;
    step_t        steps[$];
    logic         table_ready;
    logic [31:0]  lcg_state;

    tb_clock #(.period(clk_period)) u_clock (.clk(clk));

    reflet_periph_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .addr     (addr),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (data_out),
        .cpu_int  (cpu_int),
        .gpio_int (gpio_int),
        .uart_int (uart_int)
    );

    tb_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .addr       (addr),
        .write_en   (write_en),
        .data_in    (data_in),
        .data_out   (data_out),
        .cpu_int    (cpu_int),
        .gpio_int   (gpio_int),
        .uart_int   (uart_int),
        .step_done  (step_done),
        .check_data (check_data),
        .check_int  (check_int),
        .exp_value  (exp_value),
        .test_name  (test_name),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // writes and pulses take one more cycle so the check sees their effect
    function automatic int step_cycles(input step_t s);
        case (s.op)
            OP_READ:  return 1;
            OP_WAIT:  return int'(s.data);
            default:  return 2;
        endcase
    endfunction

    task automatic add_step(input op_t op, input addr_t a, input word_t d, input logic [1:0] m,
                            input word_t e, input logic [159:0] n);
        step_t s;
        s = '{op: op, addr: a, data: d, mask: m, rnd: 1'b0, expected: e, name: n};
        steps.push_back(s);
    endtask

    task automatic add_random_pulse(input logic [159:0] n);
        step_t s;
        s = '{op: OP_PULSE, addr: '0, data: '0, mask: 2'b00, rnd: 1'b1, expected: '0, name: n};
        steps.push_back(s);
    endtask

    task automatic drive_idle();
        enable     = 1'b0;
        write_en   = 1'b0;
        addr       = '0;
        data_in    = '0;
        gpio_int   = 1'b0;
        uart_int   = 1'b0;
        step_done  = 1'b0;
        check_data = 1'b0;
        check_int  = 1'b0;
    endtask

    task automatic apply_step(input step_t s);
        logic [1:0] mask;
        mask = s.mask;
        if (s.rnd) begin
            lcg_state = lcg_next(lcg_state);
            mask = lcg_state[17:16];
        end
        @(posedge clk);
        #1;
        drive_idle();
        test_name = s.name;
        exp_value = s.expected;
        case (s.op)
            OP_READ: begin
                enable = 1'b1;
                addr   = s.addr;
            end
            OP_WRITE: begin
                enable   = 1'b1;
                write_en = 1'b1;
                addr     = s.addr;
                data_in  = s.data;
                {uart_int, gpio_int} = mask;
            end
            OP_PULSE: {uart_int, gpio_int} = mask;
            default: ;
        endcase
        for (int c = 1; c < step_cycles(s); c++) begin
            @(posedge clk);
            #1;
            drive_idle();
        end
        // checked in the last cycle of the step
        step_done  = 1'b1;
        check_data = (s.op == OP_READ);
        check_int  = (s.op != OP_READ) && !s.rnd;
    endtask

    task automatic build_table();
        // a write outside both windows must leave every register at its reset value
        add_step(OP_WRITE, 16'h1234, 16'hFFFF, 2'b00, 16'h0000, "outside_write");
        add_step(OP_READ,  a_en, 16'h0000, 2'b00, 16'h0000, "rst_enable");
        add_step(OP_READ,  a_lv, 16'h0000, 2'b00, 16'h0000, "rst_level");
        add_step(OP_READ,  a_st, 16'h0000, 2'b00, 16'h0000, "rst_status");
        add_step(OP_READ,  a_rl, 16'h0000, 2'b00, 16'h0000, "rst_reload");
        add_step(OP_READ,  a_ct, 16'h0000, 2'b00, 16'h0000, "rst_control");
        add_step(OP_READ,  a_cn, 16'h0000, 2'b00, 16'h0000, "rst_count");
        add_step(OP_READ,  16'h1234, 16'h0000, 2'b00, 16'h0000, "outside_read");
        add_step(OP_READ,  16'hFF0F, 16'h0000, 2'b00, 16'h0000, "gap_read");
        // byte registers keep the low 8 bits and reload keeps all 16
        add_step(OP_WRITE, a_en, 16'hABCD, 2'b00, 16'h0000, "enable_write");
        add_step(OP_READ,  a_en, 16'h0000, 2'b00, 16'h00CD, "enable_trunc");
        add_step(OP_WRITE, a_lv, 16'h5A3C, 2'b00, 16'h0000, "level_write");
        add_step(OP_READ,  a_lv, 16'h0000, 2'b00, 16'h003C, "level_trunc");
        add_step(OP_WRITE, a_rl, 16'hBEEF, 2'b00, 16'h0000, "reload_write");
        add_step(OP_READ,  a_rl, 16'h0000, 2'b00, 16'hBEEF, "reload_full");
        add_step(OP_WRITE, a_ct, 16'h01F0, 2'b00, 16'h0000, "control_write");
        add_step(OP_READ,  a_ct, 16'h0000, 2'b00, 16'h00F0, "control_trunc");
        add_step(OP_READ,  a_cn, 16'h0000, 2'b00, 16'h0000, "count_idle");
        // gpio on line 2, uart on line 1, timer on line 3
        add_step(OP_WRITE, a_en, 16'h0001, 2'b00, 16'h0000, "enable_gpio");
        add_step(OP_WRITE, a_lv, 16'h0036, 2'b00, 16'h0000, "level_map");
        add_step(OP_PULSE, 16'h0000, 16'h0000, 2'b01, 16'h0004, "gpio_line2");
        add_step(OP_READ,  a_st, 16'h0000, 2'b00, 16'h0001, "status_gpio");
        add_step(OP_PULSE, 16'h0000, 16'h0000, 2'b10, 16'h0004, "uart_disabled");
        add_step(OP_READ,  a_st, 16'h0000, 2'b00, 16'h0003, "status_both");
        add_step(OP_WRITE, a_en, 16'h0003, 2'b00, 16'h0006, "two_lines");
        add_step(OP_WRITE, a_lv, 16'h0035, 2'b00, 16'h0002, "shared_line");
        // clearing and a write racing a pulse
        add_step(OP_WRITE, a_st, 16'h0000, 2'b00, 16'h0000, "clear_status");
        add_step(OP_READ,  a_st, 16'h0000, 2'b00, 16'h0000, "status_cleared");
        add_step(OP_PULSE, 16'h0000, 16'h0000, 2'b01, 16'h0002, "gpio_line1");
        add_step(OP_WRITE, a_st, 16'h0000, 2'b10, 16'h0002, "write_vs_pulse");
        add_step(OP_READ,  a_st, 16'h0000, 2'b00, 16'h0003, "status_merged");
        add_step(OP_WRITE, a_st, 16'h00F8, 2'b00, 16'h0000, "upper_bits");
        add_step(OP_READ,  a_st, 16'h0000, 2'b00, 16'h0000, "status_upper_zero");
        add_random_pulse("random_pulse_a");
        add_random_pulse("random_pulse_b");
        add_random_pulse("random_pulse_c");
        add_step(OP_WRITE, a_st, 16'h0000, 2'b00, 16'h0000, "clear_random");
        // reload 5 gives a wrap every 6 cycles
        add_step(OP_WRITE, a_en, 16'h0004, 2'b00, 16'h0000, "enable_timer");
        add_step(OP_WRITE, a_rl, 16'h0005, 2'b00, 16'h0000, "reload_five");
        add_step(OP_WRITE, a_ct, 16'h0001, 2'b00, 16'h0000, "timer_start");
        add_step(OP_WAIT,  16'h0000, 16'd2, 2'b00, 16'h0008, "timer_first_wrap");
        add_step(OP_WRITE, a_st, 16'h0000, 2'b00, 16'h0000, "timer_clear");
        add_step(OP_WAIT,  16'h0000, 16'd3, 2'b00, 16'h0000, "timer_not_yet");
        add_step(OP_WAIT,  16'h0000, 16'd1, 2'b00, 16'h0008, "timer_second_wrap");
        add_step(OP_READ,  a_st, 16'h0000, 2'b00, 16'h0004, "status_timer");
        add_step(OP_READ,  a_cn, 16'h0000, 2'b00, 16'h0002, "count_running");
        add_step(OP_WRITE, a_st, 16'h0000, 2'b00, 16'h0000, "timer_clear_again");
        add_step(OP_WAIT,  16'h0000, 16'd2, 2'b00, 16'h0008, "timer_third_wrap");
        add_step(OP_WRITE, a_ct, 16'h0000, 2'b00, 16'h0008, "timer_stop");
        add_step(OP_READ,  a_cn, 16'h0000, 2'b00, 16'h0002, "count_held");
        add_step(OP_WRITE, a_st, 16'h0000, 2'b00, 16'h0000, "final_clear");
        add_step(OP_WAIT,  16'h0000, 16'd10, 2'b00, 16'h0000, "timer_quiet");
    endtask

    initial begin
        rst_n       = 1'b0;
        drive_idle();
        test_name   = '0;
        exp_value   = '0;
        lcg_state   = 32'h8ede;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        @(posedge clk);
        #1;
        drive_idle();
        $display("Summary: %0d passed, %0d failed, %0d steps in table",
                 pass_count, fail_count, steps.size());
        if (fail_count == 0 && pass_count == steps.size()) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // limit from the table length plus reset and a margin
    initial begin : watchdog
        int total;
        int limit;
        total = reset_cycles + margin_cycles;
        wait (table_ready);
        foreach (steps[i]) begin
            total += step_cycles(steps[i]);
        end
        limit = total * clk_period;
        #(limit);
        $display("Timeout: simulation still running after %0d time units", limit);
        $display("Test failed");
        $finish;
    end

endmodule
